// File: Bender.yml
package:
  name: uart_periph

sources:
  - src/uart_pkg.sv
  - src/uart_fifo.sv
  - src/uart_tx.sv
  - src/uart_rx.sv
  - src/uart_regs.sv
  - src/uart_top.sv
  - target: test
    files:
      - dv/tb_clock.sv
      - dv/uart_asserts.sv
      - dv/uart_tb.sv

// File: dv/tb_clock.sv
// Testbench clock and reset.

`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
	parameter int PERIOD_NS = 40,
	parameter int RESET_CYCLES = 4
) (
	output logic o_clock,
	output logic o_reset
);
	initial begin
		o_clock = 1'b0;
		forever #(PERIOD_NS / 2) o_clock = ~o_clock;
	end

	// Released just after a rising edge.
	initial begin
		o_reset = 1'b1;
		repeat (RESET_CYCLES) @(posedge o_clock);
		#1;
		o_reset = 1'b0;
	end

endmodule

`default_nettype wire

// File: dv/uart_asserts.sv
// Register port and serial line assertions.

`timescale 1ns/1ps
`default_nettype none

module uart_asserts (
	input wire i_clock,
	input wire i_reset,
	input wire i_request,
	input wire i_ready,
	input wire i_tx_write,
	input wire i_uart_tx
);
	// Set by the first write into the transmit FIFO.
	logic tx_seen;

	// Count of failed assertions.
	int failures = 0;

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			tx_seen <= 1'b0;
		end else if (i_tx_write) begin
			tx_seen <= 1'b1;
		end
	end

	ready_needs_request: assert property (
		@(posedge i_clock) disable iff (i_reset) $rose(i_ready) |-> $past(i_request)
	) else begin
		failures++;
		$error("o_ready rose without a pending request");
	end

	line_idle_until_write: assert property (
		@(posedge i_clock) disable iff (i_reset) !tx_seen |-> i_uart_tx
	) else begin
		failures++;
		$error("serial line left idle before any transmit write");
	end

	ready_single_pulse: assert property (
		@(posedge i_clock) disable iff (i_reset) i_ready |=> !i_ready
	) else begin
		failures++;
		$error("o_ready high for two cycles in a row");
	end

endmodule

`default_nettype wire

// File: dv/uart_tb.sv
// UART peripheral testbench.

`timescale 1ns/1ps
`default_nettype none

module uart_tb;
	localparam int CLOCKS_PER_BIT = 8;
	localparam int FIFO_DEPTH = 4;
	localparam int BURST = FIFO_DEPTH + 2;
	localparam int MAX_ROWS = 12;
	localparam int BUS_TIMEOUT = 400;
	localparam int POLL_LIMIT = 150;

	// Expected status bits.
	localparam logic [31:0] F_FULL = 32'd1 << uart_pkg::STAT_TX_FULL;
	localparam logic [31:0] F_IDLE = 32'd1 << uart_pkg::STAT_TX_IDLE;
	localparam logic [31:0] F_EMPTY = 32'd1 << uart_pkg::STAT_RX_EMPTY;
	localparam logic [31:0] F_OVERRUN = 32'd1 << uart_pkg::STAT_RX_OVERRUN;
	localparam logic [31:0] F_FRAME = 32'd1 << uart_pkg::STAT_RX_FRAME;
	localparam logic [31:0] F_STICKY = F_OVERRUN | F_FRAME;

	logic clock;
	logic reset;
	logic req;
	logic wr;
	logic [uart_pkg::ADDR_WIDTH-1:0] addr;
	logic [31:0] wdata;
	logic [31:0] rdata;
	logic ready;
	logic uart_tx;
	logic uart_rx;
	logic tb_line;
	logic loopback;

	// Stimulus table with one entry per row.
	logic row_loop [MAX_ROWS];
	logic [7:0] row_byte [MAX_ROWS];
	logic row_stop [MAX_ROWS];
	logic [31:0] row_flags [MAX_ROWS];
	int row_count = 0;

	int check_count = 0;
	int error_count = 0;
	int test_count = 0;
	logic [31:0] rng_state = 32'h2932a60f;

	tb_clock #(.PERIOD_NS(40), .RESET_CYCLES(4)) clock_gen (
		.o_clock(clock),
		.o_reset(reset)
	);

	uart_top #(
		.CLOCKS_PER_BIT(CLOCKS_PER_BIT),
		.FIFO_DEPTH(FIFO_DEPTH)
	) DUT (
		.i_clock(clock),
		.i_reset(reset),
		.i_request(req),
		.i_write(wr),
		.i_address(addr),
		.i_wdata(wdata),
		.o_rdata(rdata),
		.o_ready(ready),
		.o_uart_tx(uart_tx),
		.i_uart_rx(uart_rx)
	);

	bind uart_top uart_asserts asserts (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_request(i_request),
		.i_ready(o_ready),
		.i_tx_write(tx_write),
		.i_uart_tx(o_uart_tx)
	);

	// Receive line comes from the transmitter or from the line driver.
	assign uart_rx = loopback ? uart_tx : tb_line;

	function automatic logic [31:0] lcg_next(input logic [31:0] state);
		return state * 32'd1664525 + 32'd1013904223;
	endfunction

	task automatic compare(input string what, input logic [31:0] got, input logic [31:0] expected);
		check_count++;
		if (got !== expected) begin
			error_count++;
			$display("ERR %0t ns: %s read %h, expected %h", $time, what, got, expected);
		end
	endtask

	task automatic stop_on_timeout(input string what);
		$display("Timed out at %0t ns while waiting for %s.", $time, what);
		$display("Simulation failed");
		$finish;
	endtask

	task automatic report_test(input string name, input int errors_before);
		test_count++;
		$display("%-16s %s", name, (error_count == errors_before) ? "ok" : "mismatch");
	endtask

	// One request held until the ready pulse.
	task automatic bus_access(input logic is_write, input logic [1:0] address,
			input logic [31:0] data, output logic [31:0] result);
		int waited;
		@(posedge clock);
		#1;
		req = 1'b1;
		wr = is_write;
		addr = address;
		wdata = data;
		waited = 0;
		@(posedge clock);
		#1;
		while (!ready) begin
			if (waited == BUS_TIMEOUT) begin
				stop_on_timeout("a bus ready pulse");
			end
			waited++;
			@(posedge clock);
			#1;
		end
		result = rdata;
		req = 1'b0;
		wr = 1'b0;
	endtask

	task automatic bus_write(input logic [1:0] address, input logic [31:0] data);
		logic [31:0] unused;
		bus_access(1'b1, address, data, unused);
	endtask

	task automatic bus_read(input logic [1:0] address, output logic [31:0] data);
		bus_access(1'b0, address, 32'd0, data);
	endtask

	// Poll status until one bit reaches the wanted value.
	task automatic wait_status(input int bit_pos, input logic value, input string what);
		logic [31:0] data;
		int polls;
		polls = 0;
		bus_read(uart_pkg::ADDR_STATUS, data);
		while (data[bit_pos] !== value) begin
			if (polls == POLL_LIMIT) begin
				stop_on_timeout(what);
			end
			polls++;
			bus_read(uart_pkg::ADDR_STATUS, data);
		end
	endtask

	// Start bit, data LSB first, stop bit, then one idle bit.
	task automatic drive_frame(input logic [7:0] data, input logic stop_good);
		logic [9:0] frame;
		int k;
		frame = {stop_good, data, 1'b0};
		@(posedge clock);
		#1;
		for (k = 0; k < 10; k++) begin
			tb_line = frame[k];
			repeat (CLOCKS_PER_BIT) @(posedge clock);
			#1;
		end
		tb_line = 1'b1;
		repeat (CLOCKS_PER_BIT) @(posedge clock);
		#1;
	endtask

	task automatic add_row(input logic loop, input logic [7:0] data, input logic stop_good,
			input logic [31:0] flags);
		row_loop[row_count] = loop;
		row_byte[row_count] = data;
		row_stop[row_count] = stop_good;
		row_flags[row_count] = flags;
		row_count++;
	endtask

	task automatic run_row(input int i);
		logic [31:0] data;
		int errors_before;
		errors_before = error_count;
		loopback = row_loop[i];
		if (row_loop[i]) begin
			bus_write(uart_pkg::ADDR_TXDATA, {24'd0, row_byte[i]});
		end else begin
			drive_frame(row_byte[i], row_stop[i]);
		end
		if (row_stop[i]) begin
			wait_status(uart_pkg::STAT_RX_EMPTY, 1'b0, "received data");
			bus_read(uart_pkg::ADDR_RXDATA, data);
			compare($sformatf("row %0d data", i), data, {24'd0, row_byte[i]});
		end
		if (row_loop[i]) begin
			wait_status(uart_pkg::STAT_TX_IDLE, 1'b1, "transmitter idle");
		end
		bus_read(uart_pkg::ADDR_STATUS, data);
		compare($sformatf("row %0d status", i), data, row_flags[i]);
		// Sticky flags clear on the first read.
		if ((row_flags[i] & F_STICKY) != 0) begin
			bus_read(uart_pkg::ADDR_STATUS, data);
			compare($sformatf("row %0d status", i), data, row_flags[i] & ~F_STICKY);
		end
		report_test($sformatf("row %0d", i), errors_before);
	endtask

	initial begin
		logic [31:0] data;
		logic [7:0] burst_bytes [BURST];
		int errors_before;
		int waited;
		int k;
		req = 1'b0;
		wr = 1'b0;
		addr = '0;
		wdata = '0;
		tb_line = 1'b1;
		loopback = 1'b1;

		add_row(1'b1, 8'h55, 1'b1, F_IDLE | F_EMPTY);
		add_row(1'b1, 8'ha3, 1'b1, F_IDLE | F_EMPTY);
		add_row(1'b1, 8'h00, 1'b1, F_IDLE | F_EMPTY);
		add_row(1'b1, 8'hff, 1'b1, F_IDLE | F_EMPTY);
		add_row(1'b0, 8'h3c, 1'b1, F_IDLE | F_EMPTY);
		add_row(1'b0, 8'hc5, 1'b0, F_IDLE | F_EMPTY | F_FRAME);
		while (row_count < MAX_ROWS - 2) begin
			rng_state = lcg_next(rng_state);
			add_row(1'b1, rng_state[23:16], 1'b1, F_IDLE | F_EMPTY);
		end

		waited = 0;
		while (reset) begin
			if (waited == 20) begin
				stop_on_timeout("reset release");
			end
			waited++;
			@(posedge clock);
		end

		errors_before = error_count;
		bus_read(uart_pkg::ADDR_STATUS, data);
		compare("reset status", data, F_IDLE | F_EMPTY);
		report_test("reset", errors_before);

		for (k = 0; k < row_count; k++) begin
			run_row(k);
		end

		// Writes beyond the FIFO depth stall until a slot frees.
		errors_before = error_count;
		loopback = 1'b1;
		for (k = 0; k < BURST; k++) begin
			rng_state = lcg_next(rng_state);
			burst_bytes[k] = rng_state[23:16];
			bus_write(uart_pkg::ADDR_TXDATA, {24'd0, burst_bytes[k]});
		end
		// The last stalled write refills the transmit FIFO.
		bus_read(uart_pkg::ADDR_STATUS, data);
		compare("burst tx full", data & F_FULL, F_FULL);
		for (k = 0; k < BURST; k++) begin
			wait_status(uart_pkg::STAT_RX_EMPTY, 1'b0, "burst data");
			bus_read(uart_pkg::ADDR_RXDATA, data);
			compare("burst data", data, {24'd0, burst_bytes[k]});
		end
		wait_status(uart_pkg::STAT_TX_IDLE, 1'b1, "transmitter idle");
		bus_read(uart_pkg::ADDR_STATUS, data);
		compare("burst status", data, F_IDLE | F_EMPTY);
		report_test("back-pressure", errors_before);

		// One frame more than the receive FIFO holds.
		errors_before = error_count;
		loopback = 1'b0;
		for (k = 0; k <= FIFO_DEPTH; k++) begin
			drive_frame(8'h81 + 8'(k), 1'b1);
		end
		bus_read(uart_pkg::ADDR_STATUS, data);
		compare("overrun status", data, F_IDLE | F_OVERRUN);
		bus_read(uart_pkg::ADDR_STATUS, data);
		compare("overrun status", data, F_IDLE);
		for (k = 0; k < FIFO_DEPTH; k++) begin
			bus_read(uart_pkg::ADDR_RXDATA, data);
			compare("overrun data", data, {24'd0, 8'h81 + 8'(k)});
		end
		bus_read(uart_pkg::ADDR_STATUS, data);
		compare("overrun status", data, F_IDLE | F_EMPTY);
		report_test("overrun", errors_before);

		errors_before = error_count;
		bus_read(uart_pkg::ADDR_RXDATA, data);
		compare("empty rxdata", data, 32'd0);
		bus_read(2'd3, data);
		compare("address 3", data, 32'd0);
		report_test("empty reads", errors_before);

		error_count += DUT.asserts.failures;
		$display("tests %0d, checks %0d, errors %0d", test_count, check_count, error_count);
		if (error_count == 0) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: src/uart_fifo.sv
// Byte FIFO with full and empty flags.

`timescale 1ns/1ps
`default_nettype none

module uart_fifo #(
	parameter int FIFO_DEPTH = 16
) (
	input wire i_clock,
	input wire i_reset,
	input wire i_write,
	input wire [uart_pkg::BYTE_WIDTH-1:0] i_wdata,
	input wire i_read,
	output logic [uart_pkg::BYTE_WIDTH-1:0] o_rdata,
	output logic o_empty,
	output logic o_full
);
	localparam int PTR_WIDTH = $clog2(FIFO_DEPTH);

	logic [uart_pkg::BYTE_WIDTH-1:0] mem [FIFO_DEPTH];

	// Pointers carry one extra wrap bit.
	logic [PTR_WIDTH:0] wr_ptr;
	logic [PTR_WIDTH:0] rd_ptr;

	logic do_write;
	logic do_read;

	assign do_write = i_write && !o_full;
	assign do_read = i_read && !o_empty;

	// Same index with different wrap bits means full.
	assign o_empty = (wr_ptr == rd_ptr);
	assign o_full = (wr_ptr[PTR_WIDTH-1:0] == rd_ptr[PTR_WIDTH-1:0]) &&
		(wr_ptr[PTR_WIDTH] != rd_ptr[PTR_WIDTH]);

	// Head of the queue, shown without a read cycle.
	assign o_rdata = mem[rd_ptr[PTR_WIDTH-1:0]];

	always_ff @(posedge i_clock) begin
		if (do_write) begin
			mem[wr_ptr[PTR_WIDTH-1:0]] <= i_wdata;
		end
	end

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (do_write) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (do_read) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// File: src/uart_pkg.sv
// UART register map and shared widths.

`default_nettype none

package uart_pkg;

	// Register port and character widths.
	localparam int BUS_WIDTH = 32;
	localparam int BYTE_WIDTH = 8;
	localparam int ADDR_WIDTH = 2;

	// Register addresses. Address 3 is unused and reads zero.
	localparam logic [ADDR_WIDTH-1:0] ADDR_TXDATA = 2'd0;
	localparam logic [ADDR_WIDTH-1:0] ADDR_RXDATA = 2'd1;
	localparam logic [ADDR_WIDTH-1:0] ADDR_STATUS = 2'd2;

	// Status word bit positions.
	localparam int STAT_TX_FULL = 0;
	localparam int STAT_TX_IDLE = 1;
	localparam int STAT_RX_EMPTY = 2;
	localparam int STAT_RX_OVERRUN = 3;
	localparam int STAT_RX_FRAME = 4;

endpackage

`default_nettype wire

// File: src/uart_regs.sv
// UART register decoder and status flags.

`timescale 1ns/1ps
`default_nettype none

module uart_regs (
	input wire i_clock,
	input wire i_reset,
	input wire i_request,
	input wire i_write,
	input wire [uart_pkg::ADDR_WIDTH-1:0] i_address,
	input wire [uart_pkg::BUS_WIDTH-1:0] i_wdata,
	output logic [uart_pkg::BUS_WIDTH-1:0] o_rdata,
	output logic o_ready,
	output logic o_tx_write,
	output logic [uart_pkg::BYTE_WIDTH-1:0] o_tx_byte,
	input wire i_tx_full,
	input wire i_tx_idle,
	output logic o_rx_read,
	input wire [uart_pkg::BYTE_WIDTH-1:0] i_rx_byte,
	input wire i_rx_empty,
	input wire i_overrun,
	input wire i_frame_error
);
	logic accept;
	logic tx_stall;
	logic status_read;
	logic sticky_overrun;
	logic sticky_frame;
	logic [uart_pkg::BUS_WIDTH-1:0] status_word;
	logic [uart_pkg::BUS_WIDTH-1:0] read_word;

	// A write to a full transmit FIFO waits.
	assign tx_stall = i_write && (i_address == uart_pkg::ADDR_TXDATA) && i_tx_full;

	// The ready pulse blocks a second accept of the held request.
	assign accept = i_request && !o_ready && !tx_stall;

	assign o_tx_write = accept && i_write && (i_address == uart_pkg::ADDR_TXDATA);
	assign o_tx_byte = i_wdata[uart_pkg::BYTE_WIDTH-1:0];
	assign o_rx_read = accept && !i_write && (i_address == uart_pkg::ADDR_RXDATA) &&
		!i_rx_empty;
	assign status_read = accept && !i_write && (i_address == uart_pkg::ADDR_STATUS);

	always_comb begin
		status_word = '0;
		status_word[uart_pkg::STAT_TX_FULL] = i_tx_full;
		status_word[uart_pkg::STAT_TX_IDLE] = i_tx_idle;
		status_word[uart_pkg::STAT_RX_EMPTY] = i_rx_empty;
		status_word[uart_pkg::STAT_RX_OVERRUN] = sticky_overrun;
		status_word[uart_pkg::STAT_RX_FRAME] = sticky_frame;
	end

	always_comb begin
		read_word = '0;
		if (i_address == uart_pkg::ADDR_RXDATA && !i_rx_empty) begin
			read_word[uart_pkg::BYTE_WIDTH-1:0] = i_rx_byte;
		end else if (i_address == uart_pkg::ADDR_STATUS) begin
			read_word = status_word;
		end
	end

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			o_ready <= 1'b0;
			sticky_overrun <= 1'b0;
			sticky_frame <= 1'b0;
		end else begin
			o_ready <= accept;
			// A new pulse wins over the clear of a status read.
			sticky_overrun <= (sticky_overrun && !status_read) || i_overrun;
			sticky_frame <= (sticky_frame && !status_read) || i_frame_error;
		end
	end

	// Writes return zero.
	always_ff @(posedge i_clock) begin
		if (accept) begin
			o_rdata <= i_write ? '0 : read_word;
		end
	end

endmodule

`default_nettype wire

// File: src/uart_rx.sv
// Buffered 8N1 serial receiver.

`timescale 1ns/1ps
`default_nettype none

module uart_rx #(
	parameter int CLOCKS_PER_BIT = 16,
	parameter int FIFO_DEPTH = 16
) (
	input wire i_clock,
	input wire i_reset,
	input wire i_uart_rx,
	input wire i_read,
	output logic [uart_pkg::BYTE_WIDTH-1:0] o_byte,
	output logic o_empty,
	output logic o_overrun,
	output logic o_frame_error
);
	localparam int CNT_WIDTH = $clog2(CLOCKS_PER_BIT);
	localparam logic [CNT_WIDTH-1:0] LAST_COUNT = CNT_WIDTH'(CLOCKS_PER_BIT - 1);
	localparam logic [CNT_WIDTH-1:0] HALF_COUNT = CNT_WIDTH'(CLOCKS_PER_BIT / 2 - 1);

	typedef enum logic [1:0] {
		S_IDLE,
		S_START,
		S_DATA,
		S_STOP
	} state_t;

	state_t state;

	// Two-flop synchronizer and edge history.
	logic [1:0] rx_sync;
	logic rx_last;
	logic rx_line;

	logic [CNT_WIDTH-1:0] bit_count;
	logic [2:0] bit_index;
	logic [uart_pkg::BYTE_WIDTH-1:0] shift;

	logic fifo_write;
	logic fifo_full;

	assign rx_line = rx_sync[1];

	uart_fifo #(
		.FIFO_DEPTH(FIFO_DEPTH)
	) rx_fifo (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_write(fifo_write),
		.i_wdata(shift),
		.i_read(i_read),
		.o_rdata(o_byte),
		.o_empty(o_empty),
		.o_full(fifo_full)
	);

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			rx_sync <= 2'b11;
			rx_last <= 1'b1;
		end else begin
			rx_sync <= {rx_sync[0], i_uart_rx};
			rx_last <= rx_line;
		end
	end

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			state <= S_IDLE;
			bit_count <= '0;
			bit_index <= '0;
			fifo_write <= 1'b0;
			o_overrun <= 1'b0;
			o_frame_error <= 1'b0;
		end else begin
			fifo_write <= 1'b0;
			o_overrun <= 1'b0;
			o_frame_error <= 1'b0;
			case (state)
				S_IDLE: begin
					bit_count <= '0;
					if (rx_last && !rx_line) begin
						state <= S_START;
					end
				end
				S_START: begin
					if (bit_count == HALF_COUNT) begin
						// A glitch, not a real start bit.
						bit_count <= '0;
						bit_index <= '0;
						state <= rx_line ? S_IDLE : S_DATA;
					end else begin
						bit_count <= bit_count + 1'b1;
					end
				end
				S_DATA: begin
					if (bit_count == LAST_COUNT) begin
						bit_count <= '0;
						bit_index <= bit_index + 1'b1;
						if (bit_index == 3'd7) begin
							state <= S_STOP;
						end
					end else begin
						bit_count <= bit_count + 1'b1;
					end
				end
				default: begin
					if (bit_count == LAST_COUNT) begin
						bit_count <= '0;
						state <= S_IDLE;
						if (!rx_line) begin
							o_frame_error <= 1'b1;
						end else if (fifo_full) begin
							o_overrun <= 1'b1;
						end else begin
							fifo_write <= 1'b1;
						end
					end else begin
						bit_count <= bit_count + 1'b1;
					end
				end
			endcase
		end
	end

	// Shift in LSB first at mid-bit.
	always_ff @(posedge i_clock) begin
		if (state == S_DATA && bit_count == LAST_COUNT) begin
			shift <= {rx_line, shift[uart_pkg::BYTE_WIDTH-1:1]};
		end
	end

endmodule

`default_nettype wire

// File: src/uart_top.sv
// UART peripheral top level.

`timescale 1ns/1ps
`default_nettype none

module uart_top #(
	parameter int CLOCKS_PER_BIT = 16,
	parameter int FIFO_DEPTH = 16
) (
	input wire i_clock,
	input wire i_reset,
	input wire i_request,
	input wire i_write,
	input wire [uart_pkg::ADDR_WIDTH-1:0] i_address,
	input wire [uart_pkg::BUS_WIDTH-1:0] i_wdata,
	output logic [uart_pkg::BUS_WIDTH-1:0] o_rdata,
	output logic o_ready,
	output logic o_uart_tx,
	input wire i_uart_rx
);
	// Transmit side.
	logic tx_write;
	logic [uart_pkg::BYTE_WIDTH-1:0] tx_byte;
	logic tx_full;
	logic tx_idle;

	// Receive side.
	logic rx_read;
	logic [uart_pkg::BYTE_WIDTH-1:0] rx_byte;
	logic rx_empty;
	logic rx_overrun;
	logic rx_frame_error;

	uart_regs regs (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_request(i_request),
		.i_write(i_write),
		.i_address(i_address),
		.i_wdata(i_wdata),
		.o_rdata(o_rdata),
		.o_ready(o_ready),
		.o_tx_write(tx_write),
		.o_tx_byte(tx_byte),
		.i_tx_full(tx_full),
		.i_tx_idle(tx_idle),
		.o_rx_read(rx_read),
		.i_rx_byte(rx_byte),
		.i_rx_empty(rx_empty),
		.i_overrun(rx_overrun),
		.i_frame_error(rx_frame_error)
	);

	uart_tx #(
		.CLOCKS_PER_BIT(CLOCKS_PER_BIT),
		.FIFO_DEPTH(FIFO_DEPTH)
	) tx (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_write(tx_write),
		.i_byte(tx_byte),
		.o_full(tx_full),
		.o_idle(tx_idle),
		.o_uart_tx(o_uart_tx)
	);

	uart_rx #(
		.CLOCKS_PER_BIT(CLOCKS_PER_BIT),
		.FIFO_DEPTH(FIFO_DEPTH)
	) rx (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_uart_rx(i_uart_rx),
		.i_read(rx_read),
		.o_byte(rx_byte),
		.o_empty(rx_empty),
		.o_overrun(rx_overrun),
		.o_frame_error(rx_frame_error)
	);

endmodule

`default_nettype wire

// File: src/uart_tx.sv
// Buffered 8N1 serial transmitter.

`timescale 1ns/1ps
`default_nettype none

module uart_tx #(
	parameter int CLOCKS_PER_BIT = 16,
	parameter int FIFO_DEPTH = 16
) (
	input wire i_clock,
	input wire i_reset,
	input wire i_write,
	input wire [uart_pkg::BYTE_WIDTH-1:0] i_byte,
	output logic o_full,
	output logic o_idle,
	output logic o_uart_tx
);
	localparam int CNT_WIDTH = $clog2(CLOCKS_PER_BIT);
	localparam logic [CNT_WIDTH-1:0] LAST_COUNT = CNT_WIDTH'(CLOCKS_PER_BIT - 1);

	// Bits left after the start bit: eight data bits and the stop bit.
	localparam logic [3:0] LAST_BIT = 4'd9;

	logic fifo_empty;
	logic fifo_read;
	logic [uart_pkg::BYTE_WIDTH-1:0] fifo_rdata;

	logic busy;
	logic [CNT_WIDTH-1:0] bit_count;
	logic [3:0] bit_index;
	logic [uart_pkg::BYTE_WIDTH:0] shift;

	uart_fifo #(
		.FIFO_DEPTH(FIFO_DEPTH)
	) tx_fifo (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_write(i_write),
		.i_wdata(i_byte),
		.i_read(fifo_read),
		.o_rdata(fifo_rdata),
		.o_empty(fifo_empty),
		.o_full(o_full)
	);

	// Pop as soon as the line is free.
	assign fifo_read = !busy && !fifo_empty;
	assign o_idle = !busy && fifo_empty;

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			busy <= 1'b0;
			bit_count <= '0;
			bit_index <= '0;
			o_uart_tx <= 1'b1;
		end else if (!busy) begin
			if (!fifo_empty) begin
				// Start bit goes out on the next cycle.
				busy <= 1'b1;
				bit_count <= '0;
				bit_index <= '0;
				o_uart_tx <= 1'b0;
			end
		end else if (bit_count == LAST_COUNT) begin
			bit_count <= '0;
			if (bit_index == LAST_BIT) begin
				// Stop bit done, the line stays high.
				busy <= 1'b0;
			end else begin
				o_uart_tx <= shift[0];
				bit_index <= bit_index + 1'b1;
			end
		end else begin
			bit_count <= bit_count + 1'b1;
		end
	end

	// Data LSB first, with the stop bit on top.
	always_ff @(posedge i_clock) begin
		if (fifo_read) begin
			shift <= {1'b1, fifo_rdata};
		end else if (busy && bit_count == LAST_COUNT) begin
			shift <= {1'b1, shift[uart_pkg::BYTE_WIDTH:1]};
		end
	end

endmodule

`default_nettype wire

// File: vlog.f
src/uart_pkg.sv
src/uart_fifo.sv
src/uart_tx.sv
src/uart_rx.sv
src/uart_regs.sv
src/uart_top.sv
dv/tb_clock.sv
dv/uart_asserts.sv
dv/uart_tb.sv
